// File: flist.f
rtl/axis_pkg.sv
rtl/axis_skid_reg.sv
rtl/axis_adapter.sv
rtl/axis_width_bridge.sv
+incdir+sim
sim/tb_axis_width_bridge.sv

// File: sim/tb_bridge_checks.svh
int error_count = 0;
int check_count = 0;
axis_pkg::line_beat_t exp_line_q[$];  // Expected tx_out beats in order
axis_pkg::core_beat_t exp_core_q[$];  // Expected rx_out beats in order
axis_pkg::core_beat_t gather_acc = '0;
int gather_cnt = 0;

// One line beat per kept lane, lane 0 first
task automatic split_core_beat(input axis_pkg::core_beat_t b);
  axis_pkg::line_beat_t lb;
  int top;
  top = 0;
  for (int i = 0; i < axis_pkg::CORE_BYTES; i++) begin
    if (b.keep[i]) begin
      top = i;
    end
  end
  for (int i = 0; i <= top; i++) begin
    lb.data = b.data[i*axis_pkg::BYTE_W +: axis_pkg::BYTE_W];
    lb.keep = 1'b1;
    lb.last = b.last && (i == top);  // Closing byte of the frame only
    lb.user = b.user && (i == top);
    exp_line_q.push_back(lb);
  end
endtask

// Packs low lane first, closes on the eighth byte or on last
task automatic gather_line_beat(input axis_pkg::line_beat_t b);
  gather_acc.data[gather_cnt*axis_pkg::BYTE_W +: axis_pkg::BYTE_W] = b.data;
  gather_acc.keep[gather_cnt] = b.keep;
  gather_acc.last = b.last;
  gather_acc.user = b.user;
  gather_cnt++;
  if (gather_cnt == axis_pkg::CORE_BYTES || b.last) begin
    exp_core_q.push_back(gather_acc);
    gather_acc = '0;
    gather_cnt = 0;
  end
endtask

task automatic check_line_beat(input string name, input axis_pkg::line_beat_t exp,
                               input axis_pkg::line_beat_t act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("FAIL %s: expected %h, got %h", name, exp, act);
  end
endtask

task automatic check_core_beat(input string name, input axis_pkg::core_beat_t exp,
                               input axis_pkg::core_beat_t act);
  axis_pkg::core_data_t mask;
  mask = '0;
  for (int i = 0; i < axis_pkg::CORE_BYTES; i++) begin
    if (exp.keep[i]) begin
      mask[i*axis_pkg::BYTE_W +: axis_pkg::BYTE_W] = '1;  // Lanes outside keep are don't care
    end
  end
  check_count++;
  if ((act.data & mask) !== (exp.data & mask) || act.keep !== exp.keep ||
      act.last !== exp.last || act.user !== exp.user) begin
    error_count++;
    $display("FAIL %s: expected %h, got %h", name, exp, act);
  end
endtask

task automatic take_line_beat(input axis_pkg::line_beat_t act);
  axis_pkg::line_beat_t exp;
  if (exp_line_q.size() == 0) begin
    error_count++;
    $display("tx_out delivered a beat when none was expected");
  end else begin
    exp = exp_line_q.pop_front();
    check_line_beat("tx_out", exp, act);
  end
endtask

task automatic take_core_beat(input axis_pkg::core_beat_t act);
  axis_pkg::core_beat_t exp;
  if (exp_core_q.size() == 0) begin
    error_count++;
    $display("rx_out delivered a beat when none was expected");
  end else begin
    exp = exp_core_q.pop_front();
    check_core_beat("rx_out", exp, act);
  end
endtask

// File: sim/tb_axis_width_bridge.sv
`timescale 1ns/100ps

module tb_axis_width_bridge;

  localparam int CLK_PERIOD = 40;
  localparam int N_FRAMES   = 24;  // Per test and direction
  localparam int MAX_LEN    = 40;
  // Five frame sets of up to MAX_LEN bytes at 8 cycles per byte
  localparam int TIMEOUT_CYCLES = 5 * N_FRAMES * MAX_LEN * 8 + 2000;

  logic                 clk;
  logic                 rst;
  axis_pkg::core_beat_t tx_in;
  logic                 tx_in_valid;
  logic                 tx_in_ready;
  axis_pkg::line_beat_t tx_out;
  logic                 tx_out_valid;
  logic                 tx_out_ready;
  axis_pkg::line_beat_t rx_in;
  logic                 rx_in_valid;
  logic                 rx_in_ready;
  axis_pkg::core_beat_t rx_out;
  logic                 rx_out_valid;
  logic                 rx_out_ready;
  integer               seed = 32'h863f_7dea;
  integer               tx_seed;
  integer               rx_seed;
  integer               bp_seed;
  logic                 bp_on;  // Random output back-pressure
  int                   err_mark;
  int                   sent_bytes;

  `include "tb_bridge_checks.svh"

  axis_width_bridge UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic send_tx_frame(input int len);
    axis_pkg::core_beat_t b;
    logic                 user;
    logic                 taken;
    int                   sent;
    user = $random(tx_seed) % 2 != 0;
    sent = 0;
    while (sent < len) begin
      b.data = {$random(tx_seed), $random(tx_seed)};  // Junk in unkept lanes too
      b.keep = '0;
      for (int i = 0; i < axis_pkg::CORE_BYTES && sent < len; i++) begin
        b.keep[i] = 1'b1;
        sent++;
      end
      b.last = (sent == len);
      b.user = b.last & user;
      split_core_beat(b);
      tx_in = b;
      tx_in_valid = 1'b1;
      taken = 1'b0;
      while (!taken) begin
        taken = tx_in_ready;
        @(posedge clk);
        #2;
      end
    end
    tx_in_valid = 1'b0;
    sent_bytes += len;
  endtask

  task automatic send_rx_frame(input int len);
    axis_pkg::line_beat_t b;
    logic                 user;
    logic                 taken;
    user = $random(rx_seed) % 2 != 0;
    for (int i = 0; i < len; i++) begin
      b.data = axis_pkg::byte_t'($random(rx_seed));
      b.keep = 1'b1;
      b.last = (i == len - 1);
      b.user = b.last & user;
      gather_line_beat(b);
      rx_in = b;
      rx_in_valid = 1'b1;
      taken = 1'b0;
      while (!taken) begin
        taken = rx_in_ready;
        @(posedge clk);
        #2;
      end
    end
    rx_in_valid = 1'b0;
    sent_bytes += len;
  endtask

  task automatic finish_test(input string name);
    while (exp_line_q.size() != 0 || exp_core_q.size() != 0) begin
      @(posedge clk);
      #2;
    end
    repeat (10) @(posedge clk);  // Time for any stray extra beat
    #2;
    $display("Test %s done, %0d errors", name, error_count - err_mark);
    err_mark = error_count;
  endtask

  // Snapshot at +2 ns is what the next edge sees
  initial begin : consumer
    logic                 tx_v;
    logic                 tx_r;
    logic                 rx_v;
    logic                 rx_r;
    axis_pkg::line_beat_t tx_held;
    axis_pkg::core_beat_t rx_held;
    tx_v = 1'b0;
    rx_v = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      if (tx_v && tx_r) begin
        take_line_beat(tx_held);
      end else if (tx_v) begin
        if (tx_out_valid !== 1'b1) begin
          error_count++;
          $display("tx_out_valid fell while its beat waited for ready");
        end
        check_line_beat("tx_out while stalled", tx_held, tx_out);
      end
      if (rx_v && rx_r) begin
        take_core_beat(rx_held);
      end else if (rx_v) begin
        if (rx_out_valid !== 1'b1) begin
          error_count++;
          $display("rx_out_valid fell while its beat waited for ready");
        end
        check_core_beat("rx_out while stalled", rx_held, rx_out);
      end
      tx_out_ready = bp_on ? ($unsigned($random(bp_seed)) % 10 >= 4) : 1'b1;
      rx_out_ready = bp_on ? ($unsigned($random(bp_seed)) % 10 >= 4) : 1'b1;
      tx_v = tx_out_valid;
      tx_r = tx_out_ready;
      tx_held = tx_out;
      rx_v = rx_out_valid;
      rx_r = rx_out_ready;
      rx_held = rx_out;
    end
  end

  initial begin : main_flow
    int len;
    rst = 1'b1;
    tx_in = '0;
    tx_in_valid = 1'b0;
    tx_out_ready = 1'b0;
    rx_in = '0;
    rx_in_valid = 1'b0;
    rx_out_ready = 1'b0;
    bp_on = 1'b0;
    err_mark = 0;
    sent_bytes = 0;
    tx_seed = seed;
    rx_seed = seed ^ 32'h5a5a_5a5a;
    bp_seed = seed ^ 32'h0ff0_0ff0;

    repeat (16) begin
      @(posedge clk);
      #2;
      if ({tx_out_valid, rx_out_valid, tx_in_ready, rx_in_ready} !== 4'b0000) begin
        error_count++;
        $display("A valid or ready output is not low during reset");
      end
    end
    rst = 1'b0;
    repeat (2) begin
      @(posedge clk);
      #2;
      if (tx_out_valid !== 1'b0 || rx_out_valid !== 1'b0) begin
        error_count++;
        $display("An output valid rose after reset with no input");
      end
    end
    if (tx_in_ready !== 1'b1 || rx_in_ready !== 1'b1) begin
      error_count++;
      $display("Input ready did not rise within 2 cycles of reset release");
    end
    finish_test("1 reset");

    for (int f = 0; f < N_FRAMES; f++) begin
      send_tx_frame(axis_pkg::CORE_BYTES * (1 + $unsigned($random(tx_seed)) % 5));
    end
    finish_test("2 transmit split, full frames");

    for (int f = 0; f < N_FRAMES; f++) begin
      len = 1 + $unsigned($random(tx_seed)) % MAX_LEN;
      send_tx_frame(len % 8 == 0 ? len - 1 : len);  // Closing beat always partial
    end
    finish_test("3 transmit split, partial final beats");

    for (int f = 0; f < N_FRAMES; f++) begin
      send_rx_frame(1 + $unsigned($random(rx_seed)) % MAX_LEN);
    end
    finish_test("4 receive gather");

    bp_on = 1'b1;
    fork
      for (int f = 0; f < N_FRAMES; f++) begin
        send_tx_frame(1 + $unsigned($random(tx_seed)) % MAX_LEN);
      end
      for (int f = 0; f < N_FRAMES; f++) begin
        send_rx_frame(1 + $unsigned($random(rx_seed)) % MAX_LEN);
      end
    join
    finish_test("5 back-pressure");

    $display("Summary: 5 tests, %0d checks, %0d errors, %0d bytes sent",
             check_count, error_count, sent_bytes);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    if (exp_line_q.size() != 0) begin
      $display("Timeout: tx_out queue did not drain, %0d beats left", exp_line_q.size());
    end
    if (exp_core_q.size() != 0) begin
      $display("Timeout: rx_out queue did not drain, %0d beats left", exp_core_q.size());
    end
    if (exp_line_q.size() == 0 && exp_core_q.size() == 0) begin
      $display("Timeout: queues are empty but an input beat was never accepted");
    end
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: rtl/axis_width_bridge.sv
`timescale 1ns/100ps

module axis_width_bridge (
  input  logic                 clk,
  input  logic                 rst,
  input  axis_pkg::core_beat_t tx_in,
  input  logic                 tx_in_valid,
  output logic                 tx_in_ready,
  output axis_pkg::line_beat_t tx_out,
  output logic                 tx_out_valid,
  input  logic                 tx_out_ready,
  input  axis_pkg::line_beat_t rx_in,
  input  logic                 rx_in_valid,
  output logic                 rx_in_ready,
  output axis_pkg::core_beat_t rx_out,
  output logic                 rx_out_valid,
  input  logic                 rx_out_ready
);

  axis_pkg::line_data_t tx_out_data;
  axis_pkg::line_keep_t tx_out_keep;
  logic                 tx_out_last;
  logic                 tx_out_user;
  axis_pkg::core_data_t rx_out_data;
  axis_pkg::core_keep_t rx_out_keep;
  logic                 rx_out_last;
  logic                 rx_out_user;

  // Core to line, one byte per beat
  axis_adapter #(
    .IN_BYTES (axis_pkg::CORE_BYTES),
    .OUT_BYTES(axis_pkg::LINE_BYTES)
  ) tx_split (
    .clk      (clk),
    .rst      (rst),
    .in_data  (tx_in.data),
    .in_keep  (tx_in.keep),
    .in_last  (tx_in.last),
    .in_user  (tx_in.user),
    .in_valid (tx_in_valid),
    .in_ready (tx_in_ready),
    .out_data (tx_out_data),
    .out_keep (tx_out_keep),
    .out_last (tx_out_last),
    .out_user (tx_out_user),
    .out_valid(tx_out_valid),
    .out_ready(tx_out_ready)
  );

  // Line to core, low lane first
  axis_adapter #(
    .IN_BYTES (axis_pkg::LINE_BYTES),
    .OUT_BYTES(axis_pkg::CORE_BYTES)
  ) rx_gather (
    .clk      (clk),
    .rst      (rst),
    .in_data  (rx_in.data),
    .in_keep  (rx_in.keep),
    .in_last  (rx_in.last),
    .in_user  (rx_in.user),
    .in_valid (rx_in_valid),
    .in_ready (rx_in_ready),
    .out_data (rx_out_data),
    .out_keep (rx_out_keep),
    .out_last (rx_out_last),
    .out_user (rx_out_user),
    .out_valid(rx_out_valid),
    .out_ready(rx_out_ready)
  );

  assign tx_out = '{data: tx_out_data, keep: tx_out_keep, last: tx_out_last, user: tx_out_user};
  assign rx_out = '{data: rx_out_data, keep: rx_out_keep, last: rx_out_last, user: rx_out_user};

endmodule

// File: rtl/axis_adapter.sv
`timescale 1ns/100ps

module axis_adapter #(
  parameter int IN_BYTES  = 8,
  parameter int OUT_BYTES = 1
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [IN_BYTES*axis_pkg::BYTE_W-1:0]  in_data,
  input  logic [IN_BYTES-1:0]                   in_keep,
  input  logic                                  in_last,
  input  logic                                  in_user,
  input  logic                                  in_valid,
  output logic                                  in_ready,
  output logic [OUT_BYTES*axis_pkg::BYTE_W-1:0] out_data,
  output logic [OUT_BYTES-1:0]                  out_keep,
  output logic                                  out_last,
  output logic                                  out_user,
  output logic                                  out_valid,
  input  logic                                  out_ready
);

  localparam int OUT_W      = OUT_BYTES * axis_pkg::BYTE_W;
  localparam bit EXPAND     = OUT_BYTES > IN_BYTES;
  localparam int WIDE_BYTES = EXPAND ? OUT_BYTES : IN_BYTES;
  localparam int SEG_BYTES  = EXPAND ? IN_BYTES : OUT_BYTES;  // Narrow side
  localparam int SEG        = WIDE_BYTES / SEG_BYTES;
  localparam int WIDE_W     = WIDE_BYTES * axis_pkg::BYTE_W;
  localparam int SEG_W      = SEG_BYTES * axis_pkg::BYTE_W;
  localparam int CNT_W      = $clog2(SEG + 1);

  typedef struct packed {
    logic [OUT_W-1:0]     data;
    logic [OUT_BYTES-1:0] keep;
    logic                 last;
    logic                 user;
  } out_beat_t;

  axis_pkg::adapt_state_t state;
  axis_pkg::adapt_state_t state_next;
  logic [CNT_W-1:0]       cnt;  // Slice index
  logic [CNT_W-1:0]       cnt_next;
  logic [WIDE_W-1:0]      temp_data;
  logic [WIDE_W-1:0]      temp_data_next;
  logic [WIDE_BYTES-1:0]  temp_keep;
  logic [WIDE_BYTES-1:0]  temp_keep_next;
  logic                   temp_last;
  logic                   temp_last_next;
  logic                   temp_user;
  logic                   temp_user_next;
  logic                   in_ready_next;
  logic                   in_xfer;
  logic                   ready_early;
  logic                   ready_int;  // Output stage ready, one cycle late
  logic                   load_first;
  logic                   last_seg;
  logic [SEG_W-1:0]       in_seg_data;
  logic [SEG_BYTES-1:0]   in_seg_keep;
  logic [SEG_W-1:0]       seg_data;
  logic [SEG_BYTES-1:0]   seg_keep;
  logic [SEG_BYTES-1:0]   next_keep;
  out_beat_t              beat;
  logic                   beat_valid;
  out_beat_t              skid_out;

  assign in_xfer = in_valid & in_ready;

  // Narrow view of the input when gathering
  assign in_seg_data = in_data[SEG_W-1:0];
  assign in_seg_keep = in_keep[SEG_BYTES-1:0];

  // Current and following slice of the held wide beat
  assign seg_data  = SEG_W'(temp_data >> (SEG_W * cnt));
  assign seg_keep  = SEG_BYTES'(temp_keep >> (SEG_BYTES * cnt));
  assign next_keep = SEG_BYTES'(temp_keep >> (SEG_BYTES * (cnt + 1)));

  // Top slice, partial slice, or nothing left after it
  assign last_seg = (cnt == CNT_W'(SEG - 1)) || (seg_keep != '1) || (next_keep == '0);

  always_comb begin
    state_next = state;
    cnt_next = cnt;
    temp_data_next = temp_data;
    temp_keep_next = temp_keep;
    temp_last_next = temp_last;
    temp_user_next = temp_user;
    in_ready_next = 1'b0;
    load_first = 1'b0;
    beat = '0;
    beat_valid = 1'b0;
    case (state)
      axis_pkg::IDLE: begin
        if (SEG == 1) begin
          in_ready_next = ready_early;  // Same width, straight through
          beat.data = OUT_W'(in_data);
          beat.keep = OUT_BYTES'(in_keep);
          beat.last = in_last;
          beat.user = in_user;
          beat_valid = in_valid;
        end else if (EXPAND) begin
          in_ready_next = 1'b1;
          load_first = in_xfer;
        end else begin
          in_ready_next = 1'b1;
          if (in_xfer) begin
            temp_data_next = WIDE_W'(in_data);
            temp_keep_next = WIDE_BYTES'(in_keep);
            temp_last_next = in_last;
            temp_user_next = in_user;
            cnt_next = '0;
            in_ready_next = 1'b0;
            state_next = axis_pkg::EMIT;
          end
        end
      end
      axis_pkg::GATHER: begin
        in_ready_next = 1'b1;
        if (in_xfer) begin
          temp_data_next[cnt*SEG_W +: SEG_W] = in_seg_data;
          temp_keep_next[cnt*SEG_BYTES +: SEG_BYTES] = in_seg_keep;
          temp_last_next = in_last;
          temp_user_next = in_user;
          cnt_next = cnt + 1'b1;
          if (cnt == CNT_W'(SEG - 1) || in_last) begin
            in_ready_next = ready_early;
            state_next = axis_pkg::EMIT;
          end
        end
      end
      axis_pkg::EMIT: begin
        beat_valid = 1'b1;
        if (EXPAND) begin
          beat.data = OUT_W'(temp_data);
          beat.keep = OUT_BYTES'(temp_keep);
          beat.last = temp_last;
          beat.user = temp_user;
          in_ready_next = ready_early;
          if (ready_int) begin
            if (in_xfer) begin
              load_first = 1'b1;  // Next gather overlaps this emission
            end else begin
              in_ready_next = 1'b1;
              state_next = axis_pkg::IDLE;
            end
          end
        end else begin
          beat.data = OUT_W'(seg_data);
          beat.keep = OUT_BYTES'(seg_keep);
          beat.last = temp_last & last_seg;
          beat.user = temp_user & last_seg;
          if (ready_int) begin
            cnt_next = cnt + 1'b1;
            if (last_seg) begin
              in_ready_next = 1'b1;
              state_next = axis_pkg::IDLE;
            end
          end
        end
      end
      default: begin
        state_next = axis_pkg::IDLE;
      end
    endcase

    // First narrow beat of a new wide beat, upper lanes cleared
    if (load_first) begin
      temp_data_next = WIDE_W'(in_seg_data);
      temp_keep_next = WIDE_BYTES'(in_seg_keep);
      temp_last_next = in_last;
      temp_user_next = in_user;
      cnt_next = CNT_W'(1);
      if (in_last) begin
        in_ready_next = ready_early;
        state_next = axis_pkg::EMIT;
      end else begin
        in_ready_next = 1'b1;
        state_next = axis_pkg::GATHER;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= axis_pkg::IDLE;
      cnt <= '0;
      in_ready <= 1'b0;
      ready_int <= 1'b0;
    end else begin
      state <= state_next;
      cnt <= cnt_next;
      in_ready <= in_ready_next;
      ready_int <= ready_early;
    end
  end

  always_ff @(posedge clk) begin
    temp_data <= temp_data_next;
    temp_keep <= temp_keep_next;
    temp_last <= temp_last_next;
    temp_user <= temp_user_next;
  end

  axis_skid_reg #(
    .WIDTH($bits(out_beat_t))
  ) out_skid (
    .clk           (clk),
    .rst           (rst),
    .in_data       (beat),
    .in_valid      (beat_valid),
    .in_ready_early(ready_early),
    .out_data      (skid_out),
    .out_valid     (out_valid),
    .out_ready     (out_ready)
  );

  assign out_data = skid_out.data;
  assign out_keep = skid_out.keep;
  assign out_last = skid_out.last;
  assign out_user = skid_out.user;

endmodule

// File: rtl/axis_skid_reg.sv
`timescale 1ns/100ps

module axis_skid_reg #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready_early,
  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  logic             in_ready;  // Registered copy of in_ready_early
  logic [WIDTH-1:0] temp_data;
  logic             temp_valid;
  logic             out_valid_next;
  logic             temp_valid_next;
  logic             load_out_from_in;
  logic             load_out_from_temp;
  logic             load_temp;

  // Only refuse when a stalled output and a pending input could fill both entries
  assign in_ready_early = out_ready | (~temp_valid & (~out_valid | ~in_valid));

  always_comb begin
    out_valid_next = out_valid;
    temp_valid_next = temp_valid;
    load_out_from_in = 1'b0;
    load_out_from_temp = 1'b0;
    load_temp = 1'b0;
    if (in_ready) begin
      if (out_ready || !out_valid) begin
        out_valid_next = in_valid;
        load_out_from_in = 1'b1;
      end else begin
        temp_valid_next = in_valid;  // Output stalled, park the beat
        load_temp = 1'b1;
      end
    end else if (out_ready) begin
      out_valid_next = temp_valid;
      temp_valid_next = 1'b0;
      load_out_from_temp = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_ready <= 1'b0;
      out_valid <= 1'b0;
      temp_valid <= 1'b0;
    end else begin
      in_ready <= in_ready_early;
      out_valid <= out_valid_next;
      temp_valid <= temp_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (load_out_from_in) begin
      out_data <= in_data;
    end else if (load_out_from_temp) begin
      out_data <= temp_data;
    end
    if (load_temp) begin
      temp_data <= in_data;
    end
  end

endmodule

// File: rtl/axis_pkg.sv
package axis_pkg;

  // Lane geometry of the two sides
  localparam int CORE_BYTES = 8;
  localparam int LINE_BYTES = 1;
  localparam int BYTE_W     = 8;

  typedef logic [BYTE_W-1:0] byte_t;

  // Core side, 64-bit packet core
  typedef logic [CORE_BYTES*BYTE_W-1:0] core_data_t;  // Lane 0 in the low byte
  typedef logic [CORE_BYTES-1:0]        core_keep_t;

  // Line side, one byte per beat
  typedef logic [LINE_BYTES*BYTE_W-1:0] line_data_t;
  typedef logic [LINE_BYTES-1:0]        line_keep_t;

  typedef struct packed {
    core_data_t data;
    core_keep_t keep;
    logic       last;
    logic       user;  // Frame error, valid with last
  } core_beat_t;

  typedef struct packed {
    line_data_t data;
    line_keep_t keep;
    logic       last;
    logic       user;  // Frame error, valid with last
  } line_beat_t;

  // Width adapter FSM
  typedef enum logic [1:0] {
    IDLE,
    GATHER,  // Collecting narrow beats
    EMIT     // Handing slices or the full beat to the output stage
  } adapt_state_t;

endpackage
